//--- Makefile
TOP := tb_lsu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- data_memory.sv
// =========================================================================
// Word-wide data memory with per-byte write enables and a registered read
// Strobed once per access by the memory interface
// =========================================================================
`timescale 1ns/1ps

module data_memory
    import lsu_pkg::*;
(
    input  logic       memory_done,
    input  logic       mem_enable,
    input  logic       mem_write,
    input  lane_mask_t mem_mask,
    input  mem_index_t mem_index,
    input  word_t      mem_wdata,
    output word_t      mem_rdata
);

    word_t mem_array [MEM_WORDS];

    // Only the enabled byte lanes are written
    always_ff @(posedge memory_done)
    begin
        if (mem_enable && mem_write)
        begin
            for (int lane = 0; lane < $bits(lane_mask_t); lane++)
            begin
                if (mem_mask[lane])
                begin
                    mem_array[mem_index][8*lane +: 8] <= mem_wdata[8*lane +: 8];
                end
            end
        end
    end

    // Whole word read, lane selection happens in the load/store unit
    always_ff @(posedge memory_done)
    begin
        if (mem_enable && !mem_write)
        begin
            mem_rdata <= mem_array[mem_index];   // Held until next read
        end
    end

endmodule

//--- load_store_unit.sv
// =========================================================================
// RV32I load/store decode: byte-lane masks, store alignment, load extension
// Sits between the core's held request levels and the memory interface
// =========================================================================
`timescale 1ns/1ps

module load_store_unit
    import lsu_pkg::*;
(
    input  logic       memory_done,
    input  logic       rst_n,
    input  opcode_t    opcode,
    input  funct3_t    funct3,
    input  addr_t      address,
    input  word_t      store_data,
    input  word_t      read_data,
    input  logic       mem_ready,
    output logic       enable,
    output logic       write,
    output lane_mask_t lane_mask,
    output addr_t      word_address,
    output word_t      write_data,
    output word_t      load_data,
    output logic       misaligned
);

    logic       is_load;
    logic       is_store;
    logic       size_ok;        // funct3 legal for this opcode
    logic       align_err;
    logic [1:0] offset;         // Byte within the word
    logic [4:0] lane_shift;     // offset * 8
    word_t      read_shifted;
    word_t      load_ext;

    assign is_load    = (opcode == OPC_LOAD);
    assign is_store   = (opcode == OPC_STORE);
    assign offset     = address[1:0];
    assign lane_shift = {offset, 3'b000};

    // Lane mask and store data placement per access size
    always_comb
    begin
        lane_mask  = '0;
        write_data = '0;
        size_ok    = 1'b0;
        align_err  = 1'b0;
        case (funct3)
            F3_BYTE, F3_BYTE_U:
            begin
                size_ok    = is_load || (funct3 == F3_BYTE);
                lane_mask  = 4'b0001 << offset;
                write_data = word_t'(store_data[7:0]) << lane_shift;
            end
            F3_HALF, F3_HALF_U:
            begin
                size_ok    = is_load || (funct3 == F3_HALF);
                lane_mask  = offset[1] ? 4'b1100 : 4'b0011;
                align_err  = offset[0];       // Odd byte address
                write_data = word_t'(store_data[15:0]) << lane_shift;
            end
            F3_WORD:
            begin
                size_ok    = 1'b1;
                lane_mask  = 4'b1111;
                align_err  = |offset;
                write_data = store_data;
            end
            default:
            begin
                size_ok = 1'b0;               // Not a load/store size
            end
        endcase
    end

    // A misaligned request never reaches the memory interface
    assign misaligned   = (is_load || is_store) && size_ok && align_err;
    assign enable       = (is_load || is_store) && size_ok && !align_err;
    assign write        = is_store;
    assign word_address = {address[31:2], 2'b00};

    // Addressed byte or halfword moved down to bit 0
    assign read_shifted = read_data >> lane_shift;

    always_comb
    begin
        case (funct3)
            F3_BYTE:   load_ext = {{24{read_shifted[7]}}, read_shifted[7:0]};
            F3_HALF:   load_ext = {{16{read_shifted[15]}}, read_shifted[15:0]};
            F3_BYTE_U: load_ext = {24'b0, read_shifted[7:0]};
            F3_HALF_U: load_ext = {16'b0, read_shifted[15:0]};
            default:   load_ext = read_shifted;   // LW, offset is zero
        endcase
    end

    // Request is still held by the core while mem_ready is high
    always_ff @(posedge memory_done)
    begin
        if (!rst_n)
        begin
            load_data <= '0;
        end
        else if (mem_ready && is_load)
        begin
            load_data <= load_ext;
        end
    end

endmodule

//--- lsu_asserts.sv
// ==========================================================================
// Timing checks on the memory interface handshake, bound into the sequencer
// ==========================================================================
`timescale 1ns/1ps

module lsu_asserts
    import lsu_pkg::*;
(
    input logic       memory_done,
    input logic       rst_n,
    input logic       mem_enable,
    input logic       mem_ready,
    input mif_state_t state
);

    // Completion is a single-cycle pulse
    ready_one_cycle: assert property (
        @(posedge memory_done) disable iff (!rst_n)
        mem_ready |=> !mem_ready
    ) else $error("mem_ready stayed high for more than one cycle");

    // Memory strobe answered on the following cycle
    enable_then_ready: assert property (
        @(posedge memory_done) disable iff (!rst_n)
        mem_enable |=> mem_ready
    ) else $error("mem_ready did not follow mem_enable by one cycle");

    // Never straight out of idle, only after an access
    ready_after_access: assert property (
        @(posedge memory_done) disable iff (!rst_n)
        mem_ready |-> ($past(state) == MIF_ACCESS)
    ) else $error("mem_ready raised without an access before it");

endmodule

//--- lsu_pkg.sv
// =========================================================================
// RV32I load/store encodings, data widths, memory geometry and FSM states
// Imported with a wildcard by the design modules and the testbench
// =========================================================================

package lsu_pkg;

    // Major opcodes served by the unit
    typedef logic [6:0] opcode_t;

    localparam opcode_t OPC_LOAD  = 7'b00_000_11;
    localparam opcode_t OPC_STORE = 7'b01_000_11;

    // Access size and signedness, as in funct3
    typedef logic [2:0] funct3_t;

    localparam funct3_t F3_BYTE   = 3'b000;
    localparam funct3_t F3_HALF   = 3'b001;
    localparam funct3_t F3_WORD   = 3'b010;
    localparam funct3_t F3_BYTE_U = 3'b100;
    localparam funct3_t F3_HALF_U = 3'b101;   // LHU only, no store form

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;              // Byte address

    // Bit i enables bits 8i+7 to 8i of a word
    typedef logic [3:0] lane_mask_t;

    // Data memory geometry
    localparam int unsigned MEM_WORDS = 256;

    typedef logic [$clog2(MEM_WORDS)-1:0] mem_index_t;

    // Cycles counted in the access state before the memory is strobed
    localparam int unsigned MEM_LATENCY = 2;

    // Memory interface sequencer
    typedef enum logic [1:0] {
        MIF_IDLE,       // Waiting for enable
        MIF_ACCESS,     // Latency count, then one memory strobe
        MIF_RESPOND,    // mem_ready pulse, read word valid
        MIF_RELEASE     // Held until the core drops enable
    } mif_state_t;

endpackage

//--- lsu_subsystem.sv
// =========================================================================
// Data-memory side of the core: load/store unit, interface and memory
// The core holds its request levels until done pulses
// =========================================================================
`timescale 1ns/1ps

module lsu_subsystem
    import lsu_pkg::*;
(
    input  logic    memory_done,
    input  logic    rst_n,
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  addr_t   address,
    input  word_t   store_data,
    output word_t   load_data,
    output logic    done,
    output logic    misaligned
);

    // Load/store unit to interface
    logic       enable;
    logic       write;
    lane_mask_t lane_mask;
    addr_t      word_address;
    word_t      write_data;
    word_t      read_data;
    logic       mem_ready;

    // Interface to memory
    logic       mem_enable;
    logic       mem_write;
    lane_mask_t mem_mask;
    mem_index_t mem_index;
    word_t      mem_wdata;
    word_t      mem_rdata;

    assign done = mem_ready;

    load_store_unit i_lsu (
        .memory_done  (memory_done),
        .rst_n        (rst_n),
        .opcode       (opcode),
        .funct3       (funct3),
        .address      (address),
        .store_data   (store_data),
        .read_data    (read_data),
        .mem_ready    (mem_ready),
        .enable       (enable),
        .write        (write),
        .lane_mask    (lane_mask),
        .word_address (word_address),
        .write_data   (write_data),
        .load_data    (load_data),
        .misaligned   (misaligned)
    );

    memory_interface i_mif (
        .memory_done  (memory_done),
        .rst_n        (rst_n),
        .enable       (enable),
        .write        (write),
        .lane_mask    (lane_mask),
        .word_address (word_address),
        .write_data   (write_data),
        .mem_rdata    (mem_rdata),
        .mem_enable   (mem_enable),
        .mem_write    (mem_write),
        .mem_mask     (mem_mask),
        .mem_index    (mem_index),
        .mem_wdata    (mem_wdata),
        .read_data    (read_data),
        .mem_ready    (mem_ready)
    );

    data_memory i_mem (
        .memory_done (memory_done),
        .mem_enable  (mem_enable),
        .mem_write   (mem_write),
        .mem_mask    (mem_mask),
        .mem_index   (mem_index),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata)
    );

endmodule

//--- memory_interface.sv
// =========================================================================
// Sequencer for one masked data memory access per held enable level
// Counts out the latency, strobes the memory once and pulses mem_ready
// =========================================================================
`timescale 1ns/1ps

module memory_interface
    import lsu_pkg::*;
(
    input  logic       memory_done,
    input  logic       rst_n,
    input  logic       enable,
    input  logic       write,
    input  lane_mask_t lane_mask,
    input  addr_t      word_address,
    input  word_t      write_data,
    input  word_t      mem_rdata,
    output logic       mem_enable,
    output logic       mem_write,
    output lane_mask_t mem_mask,
    output mem_index_t mem_index,
    output word_t      mem_wdata,
    output word_t      read_data,
    output logic       mem_ready
);

    typedef logic [$clog2(MEM_LATENCY + 1)-1:0] lat_cnt_t;

    mif_state_t state;
    lat_cnt_t   lat_cnt;

    // Request captured at acceptance
    logic       req_write;
    lane_mask_t req_mask;
    mem_index_t req_index;
    word_t      req_wdata;

    always_ff @(posedge memory_done)
    begin
        if (!rst_n)
        begin
            state      <= MIF_IDLE;
            lat_cnt    <= '0;
            mem_enable <= 1'b0;
        end
        else
        begin
            mem_enable <= 1'b0;         // Strobe lasts one cycle
            case (state)
                MIF_IDLE:
                begin
                    lat_cnt <= '0;
                    if (enable)
                    begin
                        state <= MIF_ACCESS;
                    end
                end
                MIF_ACCESS:
                begin
                    if (mem_enable)
                    begin
                        state <= MIF_RESPOND;   // Memory word registered now
                    end
                    else if (lat_cnt == lat_cnt_t'(MEM_LATENCY - 1))
                    begin
                        mem_enable <= 1'b1;     // Issue at end of latency count
                    end
                    else
                    begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                MIF_RESPOND:
                begin
                    state <= MIF_RELEASE;
                end
                MIF_RELEASE:
                begin
                    // A request held past done is not served again
                    if (!enable)
                    begin
                        state <= MIF_IDLE;
                    end
                end
                default:
                begin
                    state <= MIF_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge memory_done)
    begin
        if ((state == MIF_IDLE) && enable)
        begin
            req_write <= write;
            req_mask  <= lane_mask;
            req_index <= word_address[$bits(mem_index_t)+1:2];
            req_wdata <= write_data;
        end
    end

    assign mem_write = req_write;
    assign mem_mask  = req_mask;
    assign mem_index = req_index;
    assign mem_wdata = req_wdata;

    // Memory output holds the read word through the respond cycle
    assign read_data = mem_rdata;
    assign mem_ready = (state == MIF_RESPOND);

endmodule

//--- tb_lsu.sv
// ==========================================================================
// Table-driven testbench for the load/store subsystem with a byte memory model
// Loads are predicted from the model, timing and single service are checked
// ==========================================================================
`timescale 1ns/1ps

module tb_lsu
    import lsu_pkg::*;
();

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 10;
    localparam int          HOLD_CYCLES  = MEM_LATENCY + 3;    // Long enough to see a re-service
    localparam int unsigned MODEL_BYTES  = 4 * MEM_WORDS;
    localparam opcode_t     OPC_IDLE     = 7'b001_0011;       // OP-IMM, not a memory access

    typedef logic [$clog2(MODEL_BYTES)-1:0] byte_index_t;

    logic    memory_done;
    logic    rst_n;
    opcode_t opcode;
    funct3_t funct3;
    addr_t   address;
    word_t   store_data;
    word_t   load_data;
    logic    done;
    logic    misaligned;

    // Stimulus table, one entry per access
    opcode_t tbl_opcode[$];
    funct3_t tbl_funct3[$];
    addr_t   tbl_addr[$];
    word_t   tbl_data[$];
    logic    tbl_misal[$];
    logic    tbl_hold[$];

    logic [7:0]  model_mem [MODEL_BYTES];
    logic [31:0] rng_state   = 32'h73a6_f8bf;
    logic        table_built = 1'b0;
    int          hold_rows   = 0;
    int          errors;
    int          failed_tests;

    lsu_subsystem i_dut (
        .memory_done (memory_done),
        .rst_n       (rst_n),
        .opcode      (opcode),
        .funct3      (funct3),
        .address     (address),
        .store_data  (store_data),
        .load_data   (load_data),
        .done        (done),
        .misaligned  (misaligned)
    );

    // Single instance of the sequencer lives in i_dut.i_mif
    bind memory_interface lsu_asserts i_asserts (
        .memory_done (memory_done),
        .rst_n       (rst_n),
        .mem_enable  (mem_enable),
        .mem_ready   (mem_ready),
        .state       (state)
    );

    always #(CLK_PERIOD / 2) memory_done = ~memory_done;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned access_bytes(input funct3_t f3);
        case (f3)
            F3_BYTE, F3_BYTE_U: return 1;
            F3_HALF, F3_HALF_U: return 2;
            default:            return 4;
        endcase
    endfunction

    function automatic string access_name(input opcode_t op, input funct3_t f3);
        string kind;
        string size;
        kind = (op == OPC_STORE) ? "S" : "L";
        case (f3)
            F3_BYTE:   size = "B";
            F3_HALF:   size = "H";
            F3_WORD:   size = "W";
            F3_BYTE_U: size = "BU";
            F3_HALF_U: size = "HU";
            default:   size = "?";
        endcase
        return {kind, size};
    endfunction

    // Little endian, byte at addr lands in the low bits
    task automatic model_store(input funct3_t f3, input addr_t addr, input word_t data);
        int unsigned n;
        n = access_bytes(f3);
        for (int unsigned i = 0; i < n; i++)
        begin
            model_mem[byte_index_t'(addr + i)] = data[8*i +: 8];
        end
    endtask

    function automatic word_t model_load(input funct3_t f3, input addr_t addr);
        word_t       raw;
        int unsigned n;
        raw = '0;
        n   = access_bytes(f3);
        for (int unsigned i = 0; i < n; i++)
        begin
            raw[8*i +: 8] = model_mem[byte_index_t'(addr + i)];
        end
        case (f3)
            F3_BYTE: return {{24{raw[7]}}, raw[7:0]};
            F3_HALF: return {{16{raw[15]}}, raw[15:0]};
            default: return raw;                      // Unsigned forms already zero filled
        endcase
    endfunction

    task automatic add_test(input opcode_t op, input funct3_t f3, input addr_t addr,
                            input logic misal, input logic hold);
        rng_state = xorshift32(rng_state);
        tbl_opcode.push_back(op);
        tbl_funct3.push_back(f3);
        tbl_addr.push_back(addr);
        tbl_data.push_back(rng_state);
        tbl_misal.push_back(misal);
        tbl_hold.push_back(hold);
        if (hold)
        begin
            hold_rows++;
        end
    endtask

    task automatic build_table();
        // Word round trip
        add_test(OPC_STORE, F3_WORD,   32'h010, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_WORD,   32'h010, 1'b0, 1'b0);
        // Byte lanes of one word
        add_test(OPC_STORE, F3_WORD,   32'h020, 1'b0, 1'b0);
        add_test(OPC_STORE, F3_BYTE,   32'h020, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_WORD,   32'h020, 1'b0, 1'b0);
        add_test(OPC_STORE, F3_BYTE,   32'h021, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_BYTE,   32'h021, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_BYTE_U, 32'h021, 1'b0, 1'b0);
        add_test(OPC_STORE, F3_BYTE,   32'h022, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_BYTE,   32'h022, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_BYTE_U, 32'h022, 1'b0, 1'b0);
        add_test(OPC_STORE, F3_BYTE,   32'h023, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_BYTE,   32'h023, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_BYTE_U, 32'h023, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_BYTE,   32'h020, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_BYTE_U, 32'h020, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_WORD,   32'h020, 1'b0, 1'b0);
        // Halfword lanes
        add_test(OPC_STORE, F3_WORD,   32'h030, 1'b0, 1'b0);
        add_test(OPC_STORE, F3_HALF,   32'h030, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_HALF,   32'h030, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_HALF_U, 32'h030, 1'b0, 1'b0);
        add_test(OPC_STORE, F3_HALF,   32'h032, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_HALF,   32'h032, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_HALF_U, 32'h032, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_WORD,   32'h030, 1'b0, 1'b0);
        // Misaligned, then aligned reads show memory untouched
        add_test(OPC_LOAD,  F3_HALF,   32'h031, 1'b1, 1'b0);
        add_test(OPC_STORE, F3_HALF,   32'h033, 1'b1, 1'b0);
        add_test(OPC_LOAD,  F3_HALF_U, 32'h035, 1'b1, 1'b0);
        add_test(OPC_LOAD,  F3_WORD,   32'h032, 1'b1, 1'b0);
        add_test(OPC_STORE, F3_WORD,   32'h011, 1'b1, 1'b0);
        add_test(OPC_STORE, F3_WORD,   32'h022, 1'b1, 1'b0);
        add_test(OPC_LOAD,  F3_WORD,   32'h010, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_WORD,   32'h030, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_WORD,   32'h020, 1'b0, 1'b0);
        // Requests held past done, top word of the memory
        add_test(OPC_LOAD,  F3_WORD,   32'h010, 1'b0, 1'b1);
        add_test(OPC_STORE, F3_WORD,   32'h3fc, 1'b0, 1'b1);
        add_test(OPC_LOAD,  F3_HALF_U, 32'h3fe, 1'b0, 1'b0);
        add_test(OPC_LOAD,  F3_BYTE,   32'h3ff, 1'b0, 1'b0);
    endtask

    task automatic drive_idle();
        opcode     = OPC_IDLE;
        funct3     = F3_BYTE;
        address    = '0;
        store_data = '0;
    endtask

    task automatic check_reset_state();
        @(negedge memory_done);
        assert (!done && !misaligned && (load_data === '0))
        else
        begin
            $display("ERR %0t: after reset done=%b misaligned=%b load_data=0x%08h",
                     $time, done, misaligned, load_data);
            errors++;
        end
        $display("reset state: %s", (errors == 0) ? "pass" : "fail");
    endtask

    task automatic run_test(input int idx);
        opcode_t op;
        funct3_t f3;
        addr_t   addr;
        string   name;
        word_t   prev_load;
        word_t   expected;
        int      waited;
        int      errs_before;
        logic    got_done;
        op          = tbl_opcode[idx];
        f3          = tbl_funct3[idx];
        addr        = tbl_addr[idx];
        name        = access_name(op, f3);
        errs_before = errors;
        @(posedge memory_done);
        #5;
        prev_load  = load_data;
        opcode     = op;
        funct3     = f3;
        address    = addr;
        store_data = tbl_data[idx];
        if (tbl_misal[idx])
        begin
            repeat (MEM_LATENCY + 3)
            begin
                @(negedge memory_done);
                assert (misaligned && !done)
                else
                begin
                    $display("ERR %0t: test %0d %s misaligned=%b done=%b, expected 1 and 0",
                             $time, idx, name, misaligned, done);
                    errors++;
                end
            end
            assert (load_data === prev_load)
            else
            begin
                $display("ERR %0t: test %0d %s load_data changed to 0x%08h",
                         $time, idx, name, load_data);
                errors++;
            end
        end
        else
        begin
            waited   = 0;
            got_done = 1'b0;
            while (!got_done && (waited < MEM_LATENCY + 4))
            begin
                @(negedge memory_done);
                waited++;
                if (waited == 1)
                begin
                    assert (!misaligned)
                    else
                    begin
                        $display("ERR %0t: test %0d %s misaligned raised on aligned access",
                                 $time, idx, name);
                        errors++;
                    end
                end
                got_done = done;
            end
            if (!got_done)
            begin
                $display("Test %0d %s got no done within %0d cycles", idx, name, waited);
                errors++;
            end
            else
            begin
                // Request sampled after the first negedge and done seen a negedge late
                assert (waited == MEM_LATENCY + 3)
                else
                begin
                    $display("ERR %0t: test %0d %s done after %0d cycles, expected %0d",
                             $time, idx, name, waited - 2, MEM_LATENCY + 1);
                    errors++;
                end
                if (tbl_hold[idx])
                begin
                    repeat (HOLD_CYCLES)
                    begin
                        @(negedge memory_done);
                        assert (!done)
                        else
                        begin
                            $display("ERR %0t: test %0d %s second done on held request",
                                     $time, idx, name);
                            errors++;
                        end
                    end
                end
            end
            @(posedge memory_done);   // Load word captured on this edge
            #5;
            drive_idle();
            @(negedge memory_done);
            if (op == OPC_STORE)
            begin
                model_store(f3, addr, tbl_data[idx]);
                expected = prev_load;
            end
            else
            begin
                expected = model_load(f3, addr);
            end
            assert (!done && (load_data === expected))
            else
            begin
                $display("ERR %0t: test %0d %s load_data 0x%08h done=%b, expected 0x%08h",
                         $time, idx, name, load_data, done, expected);
                errors++;
            end
        end
        if (errors != errs_before)
        begin
            failed_tests++;
        end
        $display("test %0d %s addr 0x%03h: %s", idx, name, addr[11:0],
                 (errors == errs_before) ? "pass" : "fail");
    endtask

    initial
    begin
        int watchdog_cycles;
        wait (table_built);
        watchdog_cycles = RESET_CYCLES + tbl_opcode.size() * (MEM_LATENCY + 4)
                          + hold_rows * HOLD_CYCLES + 2;
        #(watchdog_cycles * CLK_PERIOD);
        $display("Watchdog expired, the run did not end within %0d cycles", watchdog_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        memory_done  = 1'b0;
        rst_n        = 1'b0;
        errors       = 0;
        failed_tests = 0;
        drive_idle();
        build_table();
        table_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge memory_done);
        #5;
        rst_n = 1'b1;
        check_reset_state();
        foreach (tbl_opcode[i])
        begin
            run_test(i);
        end
        $display("%0d tests run, %0d failed, %0d errors",
                 tbl_opcode.size(), failed_tests, errors);
        if (errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
lsu_pkg.sv
data_memory.sv
memory_interface.sv
load_store_unit.sv
lsu_subsystem.sv
lsu_asserts.sv
tb_lsu.sv
